//--- verilog/rt_pkg.sv
`default_nettype none

package rt_pkg;

  // Q8.8 coordinate and Q16.16 product
  typedef logic signed [15:0] fixed_t;
  typedef logic [31:0] wide_t;

  typedef logic [5:0] coord_t;
  typedef logic [11:0] fb_addr_t;
  typedef logic [7:0] color_t;

  // round-robin schedule shared by the arithmetic
  typedef enum logic [1:0] {PH0, PH1, PH2} phase_t;

  localparam int SCREEN_W = 64;
  localparam int SCREEN_H = 64;

  // 1/32 per pixel, so the screen spans -1.0 to just under +1.0
  localparam fixed_t PIXEL_STEP = 16'sd8;

  // eye at distance 4 and unit sphere give tan^2 = 1/15
  localparam wide_t HIT_LIMIT = 32'h0000_1111;

  localparam color_t HIT_COLOR = 8'd255;
  localparam color_t BG_COLOR = 8'd16;

  localparam int FIFO_DEPTH_LOG2 = 3;

endpackage

`default_nettype wire

//--- verilog/ray_if.sv
`timescale 1ns/10ps
`default_nettype none

// one primary ray, generator to intersection
interface ray_if import rt_pkg::*; ();

  logic   valid;
  logic   ready;
  coord_t x;
  coord_t y;
  fixed_t dx;
  fixed_t dy;

  modport source (output valid, x, y, dx, dy, input ready);
  modport sink (input valid, x, y, dx, dy, output ready);

endinterface

`default_nettype wire

//--- verilog/pix_if.sv
`timescale 1ns/10ps
`default_nettype none

// write side of the pixel buffer
interface pix_if import rt_pkg::*; ();

  logic     push;
  logic     full;
  fb_addr_t addr;
  color_t   color;

  modport source (output push, addr, color, input full);
  modport sink (input push, addr, color, output full);

endinterface

`default_nettype wire

//--- verilog/rt_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module rt_ctrl import rt_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   start,
  input  logic   retire,
  output phase_t phase,
  output logic   busy,
  output logic   done
);

  logic     start_q;
  logic     start_rise;
  fb_addr_t retired;

  assign start_rise = start & ~start_q;

  // edge detector and the three-phase counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_q <= 1'b0;
      phase   <= PH0;
    end else begin
      start_q <= start;
      case (phase)
        PH0:     phase <= PH1;
        PH1:     phase <= PH2;
        default: phase <= PH0;
      endcase
    end
  end

  // frame state, one retire per completed bus write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      retired <= '0;
    end else begin
      done <= 1'b0;
      if (!busy && start_rise) begin
        busy    <= 1'b1;
        retired <= '0;
      end else if (busy && retire) begin
        if (retired == fb_addr_t'(SCREEN_W * SCREEN_H - 1)) begin
          // last pixel of the frame is in memory
          busy    <= 1'b0;
          done    <= 1'b1;
          retired <= '0;
        end else begin
          retired <= retired + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/ray_gen.sv
`timescale 1ns/10ps
`default_nettype none

module ray_gen import rt_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  phase_t phase,
  input  logic   busy,
  ray_if.source  ray
);

  logic   busy_q;
  logic   scan_done;
  logic   load;
  coord_t scan_x;
  coord_t scan_y;
  fixed_t off_x;
  fixed_t off_y;

  // pixel offsets from screen centre
  assign off_x = fixed_t'(scan_x) - fixed_t'(SCREEN_W / 2);
  assign off_y = fixed_t'(scan_y) - fixed_t'(SCREEN_H / 2);

  // load during PH2 so the ray is on the bus for PH0
  assign load = busy & ~scan_done & ~ray.valid & (phase == PH2);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      ray.valid <= 1'b0;
      scan_x    <= '0;
      scan_y    <= '0;
      scan_done <= 1'b0;
    end else begin
      busy_q <= busy;
      if (busy && !busy_q) begin
        // new frame
        scan_x    <= '0;
        scan_y    <= '0;
        scan_done <= 1'b0;
        ray.valid <= 1'b0;
      end else if (load) begin
        ray.valid <= 1'b1;
        if (scan_x == coord_t'(SCREEN_W - 1)) begin
          scan_x <= '0;
          if (scan_y == coord_t'(SCREEN_H - 1)) begin
            scan_done <= 1'b1;
          end else begin
            scan_y <= scan_y + 1'b1;
          end
        end else begin
          scan_x <= scan_x + 1'b1;
        end
      end else if (ray.valid && ray.ready) begin
        ray.valid <= 1'b0;
      end
    end
  end

  // ray fields stay put until the next load
  always_ff @(posedge clk) begin
    if (load) begin
      ray.x  <= scan_x;
      ray.y  <= scan_y;
      ray.dx <= off_x * PIXEL_STEP;
      ray.dy <= off_y * PIXEL_STEP;
    end
  end

endmodule

`default_nettype wire

//--- verilog/sphere_isect.sv
`timescale 1ns/10ps
`default_nettype none

module sphere_isect import rt_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  phase_t phase,
  ray_if.sink    ray,
  pix_if.source  pix
);

  logic     held;
  logic     summed;
  logic     accept;
  logic     hit;
  fixed_t   held_dx;
  fixed_t   held_dy;
  fb_addr_t held_addr;
  fixed_t   mult_in;
  wide_t    square;
  wide_t    r2;

  // result leaves on PH0, a new ray may enter in the same cycle
  assign pix.push  = held & summed & ~pix.full;
  assign ray.ready = (phase == PH0) & (~held | pix.push);
  assign accept    = ray.valid & ray.ready;

  // one signed multiplier, dx in PH1 and dy in PH2
  assign mult_in = (phase == PH1) ? held_dx : held_dy;
  assign square  = mult_in * mult_in;

  // hit test and shading by distance from the centre
  assign hit       = r2 < HIT_LIMIT;
  assign pix.addr  = held_addr;
  assign pix.color = hit ? HIT_COLOR - {r2[15:10], 2'b00} : BG_COLOR;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      held   <= 1'b0;
      summed <= 1'b0;
    end else if (accept) begin
      held   <= 1'b1;
      summed <= 1'b0;
    end else if (pix.push) begin
      held <= 1'b0;
    end else if (held && !summed && phase == PH2) begin
      summed <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      held_dx   <= ray.dx;
      held_dy   <= ray.dy;
      held_addr <= {ray.y, ray.x};
    end
    // accumulate r2 while the ray is still being processed
    if (held && !summed) begin
      if (phase == PH1) begin
        r2 <= square;
      end else if (phase == PH2) begin
        r2 <= r2 + square;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/pixel_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_fifo import rt_pkg::*; #(
  parameter int DEPTH_LOG2 = FIFO_DEPTH_LOG2
) (
  input  logic     clk,
  input  logic     rst_n,
  pix_if.sink      pix,
  input  logic     pop,
  output logic     empty,
  output fb_addr_t rd_addr,
  output color_t   rd_color
);

  // extra msb tells full from empty
  logic [DEPTH_LOG2:0] wr_ptr;
  logic [DEPTH_LOG2:0] rd_ptr;
  logic                do_push;
  logic                do_pop;

  fb_addr_t addr_mem [2**DEPTH_LOG2];
  color_t   color_mem [2**DEPTH_LOG2];

  assign empty    = (wr_ptr == rd_ptr);
  assign pix.full = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                    (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

  assign do_push = pix.push & ~pix.full;
  assign do_pop  = pop & ~empty;

  // head entry, shown without a read cycle
  assign rd_addr  = addr_mem[rd_ptr[DEPTH_LOG2-1:0]];
  assign rd_color = color_mem[rd_ptr[DEPTH_LOG2-1:0]];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      addr_mem[wr_ptr[DEPTH_LOG2-1:0]]  <= pix.addr;
      color_mem[wr_ptr[DEPTH_LOG2-1:0]] <= pix.color;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fb_writer.sv
`timescale 1ns/10ps
`default_nettype none

module fb_writer import rt_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     empty,
  input  fb_addr_t rd_addr,
  input  color_t   rd_color,
  output logic     pop,
  output logic     retire,
  output logic     wb_cyc,
  output logic     wb_stb,
  output logic     wb_we,
  output fb_addr_t wb_adr,
  output color_t   wb_dat_w,
  input  logic     wb_ack
);

  typedef enum logic {IDLE, WRITE} wr_state_t;

  wr_state_t state;

  // bus strobes follow the state register directly
  assign wb_cyc = (state == WRITE);
  assign wb_stb = (state == WRITE);
  assign wb_we  = (state == WRITE);

  // entry leaves the buffer when memory takes it
  assign pop    = (state == WRITE) & wb_ack;
  assign retire = pop;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (!empty) state <= WRITE;
        default: if (wb_ack) state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && !empty) begin
      wb_adr   <= rd_addr;
      wb_dat_w <= rd_color;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rt_top.sv
`timescale 1ns/10ps
`default_nettype none

module rt_top import rt_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  output logic     busy,
  output logic     done,
  output logic     wb_cyc,
  output logic     wb_stb,
  output logic     wb_we,
  output fb_addr_t wb_adr,
  output color_t   wb_dat_w,
  input  logic     wb_ack
);

  phase_t   phase;
  logic     retire;
  logic     fifo_pop;
  logic     fifo_empty;
  fb_addr_t rd_addr;
  color_t   rd_color;

  ray_if ray_bus ();
  pix_if pix_bus ();

  rt_ctrl ctrl (
    .clk, .rst_n,
    .start, .retire,
    .phase, .busy, .done
  );

  // primary rays, one per pixel
  ray_gen gen (
    .clk, .rst_n,
    .phase, .busy,
    .ray (ray_bus.source)
  );

  sphere_isect isect (
    .clk, .rst_n,
    .phase,
    .ray (ray_bus.sink),
    .pix (pix_bus.source)
  );

  pixel_fifo #(.DEPTH_LOG2(FIFO_DEPTH_LOG2)) pb_fifo (
    .clk, .rst_n,
    .pix      (pix_bus.sink),
    .pop      (fifo_pop),
    .empty    (fifo_empty),
    .rd_addr, .rd_color
  );

  // frame buffer writes go out over wishbone
  fb_writer fbw (
    .clk, .rst_n,
    .empty    (fifo_empty),
    .rd_addr, .rd_color,
    .pop      (fifo_pop),
    .retire,
    .wb_cyc, .wb_stb, .wb_we,
    .wb_adr, .wb_dat_w, .wb_ack
  );

endmodule

`default_nettype wire

//--- test/rt_checker.sv
`timescale 1ns/10ps
`default_nettype none

module rt_checker import rt_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     start,
  input logic     busy,
  input logic     done,
  input logic     wb_cyc,
  input logic     wb_stb,
  input logic     wb_we,
  input fb_addr_t wb_adr,
  input color_t   wb_dat_w,
  input logic     wb_ack
);

  // outputs come out of reset low
  a_reset_low: assert property (@(posedge clk)
    !rst_n |=> !wb_cyc && !wb_stb && !wb_we && !busy && !done)
    else $error("outputs not low after reset");

  a_idle_stays: assert property (@(posedge clk) disable iff (!rst_n)
    !busy && !$rose(start) |=> !busy)
    else $error("busy rose without a start edge");

  a_no_bus_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> !wb_cyc)
    else $error("bus cycle outside a frame");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> !busy ##1 !done)
    else $error("done is not a single cycle pulse with busy low");

  // wishbone classic write rules
  a_cyc_stb: assert property (@(posedge clk) disable iff (!rst_n)
    wb_cyc == wb_stb)
    else $error("cyc and stb differ");

  a_we: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb |-> wb_we)
    else $error("strobe without write enable");

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_w))
    else $error("bus request changed before ack");

  a_drop: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb && wb_ack |=> !wb_stb)
    else $error("strobe still high after ack");

endmodule

bind rt_top rt_checker chk_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .start    (start),
  .busy     (busy),
  .done     (done),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_we    (wb_we),
  .wb_adr   (wb_adr),
  .wb_dat_w (wb_dat_w),
  .wb_ack   (wb_ack)
);

`default_nettype wire

//--- test/tb_rt_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rt_top import rt_pkg::*; ();

  // two frames at worst about 7 cycles per pixel, plus idle time
  localparam int TIMEOUT_CYCLES = 2 * 4096 * 7 + 500;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     start;
  logic     busy;
  logic     done;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  fb_addr_t wb_adr;
  color_t   wb_dat_w;
  logic     wb_ack;

  logic [7:0] mem [4096];
  logic [7:0] first_img [4096];
  int         wr_cnt [4096];
  int         writes = 0;
  int         errors = 0;
  int         done_cnt = 0;
  int         cycle_cnt = 0;

  rt_top dut_i (
    .clk, .rst_n, .start, .busy, .done,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack
  );

  always #10 clk = ~clk;

  task automatic check_eq(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // grey level from the hit rule, Q8.8 offsets squared into Q16.16
  function automatic int expected_color(input int addr);
    int dx;
    int dy;
    int r2;
    dx = (addr % 64 - 32) * 8;
    dy = (addr / 64 - 32) * 8;
    r2 = dx * dx + dy * dy;
    if (r2 < 'h1111) begin
      return 255 - (((r2 >> 10) & 63) << 2);
    end
    return 16;
  endfunction

  task automatic store_write(input int addr, input int data);
    mem[addr] = data[7:0];
    wr_cnt[addr]++;
    writes++;
    check_eq($sformatf("pixel_value@%0d", addr), expected_color(addr), data);
  endtask

  // slave with 0..3 wait states, now and then a long stall
  initial begin
    int waits;
    void'($urandom(58088));
    wb_ack = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (wb_cyc) begin
        if ($urandom % 32 == 0) begin
          waits = 40;
        end else begin
          waits = $urandom % 4;
        end
        repeat (waits) begin
          @(posedge clk);
          #1;
        end
        wb_ack = 1'b1;
        store_write(wb_adr, wb_dat_w);
        @(posedge clk);
        #1;
        wb_ack = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && done) begin
      done_cnt++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles without finishing the frames", cycle_cnt);
      $display("errors: %0d", errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic run_frame(input int frame_no);
    int a;
    int bad;
    int diff;
    wr_cnt = '{default: 0};
    writes = 0;
    start = 1'b1;
    @(posedge clk);
    #1;
    check_eq("busy_after_start", 1, busy);
    repeat (2) @(posedge clk);
    #1 start = 1'b0;
    // second edge in mid frame must not restart the scan
    repeat (300) @(posedge clk);
    #1 start = 1'b1;
    repeat (2) @(posedge clk);
    #1 start = 1'b0;
    check_eq("busy_mid_frame", 1, busy);
    while (done_cnt < frame_no) @(posedge clk);
    #1;
    check_eq("busy_after_done", 0, busy);
    bad = 0;
    diff = 0;
    for (a = 0; a < 4096; a++) begin
      if (wr_cnt[a] != 1) bad++;
      if (frame_no > 1 && mem[a] != first_img[a]) diff++;
    end
    check_eq("writes_per_frame", 4096, writes);
    check_eq("addresses_not_written_once", 0, bad);
    if (frame_no == 1) begin
      first_img = mem;
    end else begin
      check_eq("pixels_differing_from_first_frame", 0, diff);
    end
    repeat (50) @(posedge clk);
    #1;
    check_eq("done_pulses", frame_no, done_cnt);
    check_eq("busy_stays_low", 0, busy);
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    // idle with no start edge
    repeat (20) @(posedge clk);
    #1;
    check_eq("idle_busy", 0, busy);
    check_eq("idle_done", 0, done);
    check_eq("idle_wb_cyc", 0, wb_cyc);
    run_frame(1);
    run_frame(2);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
verilog/rt_pkg.sv
verilog/ray_if.sv
verilog/pix_if.sv
verilog/rt_ctrl.sv
verilog/ray_gen.sv
verilog/sphere_isect.sv
verilog/pixel_fifo.sv
verilog/fb_writer.sv
verilog/rt_top.sv
test/rt_checker.sv
test/tb_rt_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rt_top -f build.f

./obj_dir/Vtb_rt_top | tee sim.log

if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
